// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // word address width, control-select bit sits above it
   localparam int ADDR_W      = 10;
   localparam int DATA_W      = 32;
   localparam int NBYTES      = 4;
   localparam int NLINES_W    = 4;
   localparam int TAG_W       = ADDR_W - NLINES_W;
   localparam int WTB_DEPTH_W = 2;
   localparam int CNT_W       = 16;
   localparam int CTRL_ADDR_W = 3;

   // registered host request, non-zero wstrb is a write
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } fe_req_t;

   // pending memory write
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } wtb_entry_t;

   // memory port request, all-zero wstrb is a read
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } be_req_t;

   typedef enum logic [CTRL_ADDR_W-1:0] {
      CTRL_READ_HIT   = 3'd0,
      CTRL_READ_MISS  = 3'd1,
      CTRL_WRITE_HIT  = 3'd2,
      CTRL_WRITE_MISS = 3'd3,
      CTRL_WTB_EMPTY  = 3'd4,
      CTRL_INVALIDATE = 3'd7
   } ctrl_reg_e;

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL_WAIT,
      WTB_WAIT
   } mem_state_e;

   typedef enum logic [1:0] {
      BE_IDLE,
      BE_WRITE,
      BE_READ
   } be_state_e;

endpackage

`default_nettype wire

// ==== logic/cache_front_end.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_front_end (
   input  wire                               clk_i,
   input  wire                               reset_i,
   // host port
   input  wire                               req_i,
   input  wire  [cache_pkg::ADDR_W:0]        addr_i,
   input  wire  [cache_pkg::DATA_W-1:0]      wdata_i,
   input  wire  [cache_pkg::NBYTES-1:0]      wstrb_i,
   output logic [cache_pkg::DATA_W-1:0]      rdata_o,
   output logic                              ack_o,
   // cache memory side
   output logic                              data_req_o,
   output cache_pkg::fe_req_t                data_o,
   input  wire                               data_ack_i,
   input  wire  [cache_pkg::DATA_W-1:0]      data_rdata_i,
   // control side
   output logic                              ctrl_req_o,
   output logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr_o,
   output logic                              ctrl_write_o,
   input  wire                               ctrl_ack_i,
   input  wire  [cache_pkg::DATA_W-1:0]      ctrl_rdata_i
);

   logic ctrl_sel;

   // top address bit picks the control space
   assign ctrl_sel = addr_i[cache_pkg::ADDR_W];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         data_req_o <= 1'b0;
         ctrl_req_o <= 1'b0;
      end else begin
         data_req_o <= req_i & ~ctrl_sel;
         ctrl_req_o <= req_i & ctrl_sel;
      end
   end

   // payload stays put until the next host request
   always_ff @(posedge clk_i) begin
      if (req_i) begin
         data_o.addr  <= addr_i[cache_pkg::ADDR_W-1:0];
         data_o.wdata <= wdata_i;
         data_o.wstrb <= wstrb_i;
         ctrl_addr_o  <= addr_i[cache_pkg::CTRL_ADDR_W-1:0];
         ctrl_write_o <= |wstrb_i;
      end
   end

   // one registered cycle on the way back
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= data_ack_i | ctrl_ack_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (data_ack_i) begin
         rdata_o <= data_rdata_i;
      end else if (ctrl_ack_i) begin
         rdata_o <= ctrl_rdata_i;
      end
   end

endmodule

`default_nettype wire

// ==== logic/write_through_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_through_buffer (
   input  wire                        clk_i,
   input  wire                        reset_i,
   input  wire                        push_i,
   input  wire cache_pkg::wtb_entry_t push_data_i,
   input  wire                        pop_i,
   output cache_pkg::wtb_entry_t      pop_data_o,
   output logic                       full_o,
   output logic                       empty_o
);

   cache_pkg::wtb_entry_t              mem [2**cache_pkg::WTB_DEPTH_W];
   logic [cache_pkg::WTB_DEPTH_W-1:0]  wr_ptr;
   logic [cache_pkg::WTB_DEPTH_W-1:0]  rd_ptr;
   logic [cache_pkg::WTB_DEPTH_W:0]    count;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // oldest entry shows without a pop
   assign pop_data_o = mem[rd_ptr];

   // count msb set only at full depth
   assign full_o  = count[cache_pkg::WTB_DEPTH_W];
   assign empty_o = (count == '0);

endmodule

`default_nettype wire

// ==== logic/cache_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_memory (
   input  wire                           clk_i,
   input  wire                           reset_i,
   // front end
   input  wire                           data_req_i,
   input  wire cache_pkg::fe_req_t       data_i,
   output logic                          data_ack_o,
   output logic [cache_pkg::DATA_W-1:0]  data_rdata_o,
   input  wire                           invalidate_i,
   // write-through buffer
   input  wire                           wtb_full_i,
   input  wire                           wtb_empty_i,
   output logic                          wtb_push_o,
   output cache_pkg::wtb_entry_t         wtb_data_o,
   // line refill
   output logic                          refill_req_o,
   output logic [cache_pkg::ADDR_W-1:0]  refill_addr_o,
   input  wire                           refill_ack_i,
   input  wire  [cache_pkg::DATA_W-1:0]  refill_rdata_i,
   // event pulses for the counters
   output logic                          read_hit_o,
   output logic                          read_miss_o,
   output logic                          write_hit_o,
   output logic                          write_miss_o
);

   cache_pkg::mem_state_e                state;
   cache_pkg::fe_req_t                   req_q;
   logic                                 ack_q;
   logic [2**cache_pkg::NLINES_W-1:0]    valid;
   logic [cache_pkg::TAG_W-1:0]          tag_mem  [2**cache_pkg::NLINES_W];
   logic [cache_pkg::DATA_W-1:0]         data_mem [2**cache_pkg::NLINES_W];
   logic [cache_pkg::NLINES_W-1:0]       idx;
   logic [cache_pkg::TAG_W-1:0]          tag;
   logic                                 hit;
   logic                                 is_write;
   logic                                 lookup;
   logic                                 refill_done;

   assign idx         = req_q.addr[cache_pkg::NLINES_W-1:0];
   assign tag         = req_q.addr[cache_pkg::ADDR_W-1:cache_pkg::NLINES_W];
   assign hit         = valid[idx] && (tag_mem[idx] == tag);
   assign is_write    = |req_q.wstrb;
   assign lookup      = (state == cache_pkg::LOOKUP);
   assign refill_done = (state == cache_pkg::REFILL_WAIT) && refill_ack_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state <= cache_pkg::IDLE;
         ack_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         case (state)
            cache_pkg::IDLE: begin
               if (data_req_i) begin
                  state <= cache_pkg::LOOKUP;
               end
            end
            cache_pkg::LOOKUP: begin
               if (!is_write) begin
                  state <= hit ? cache_pkg::IDLE : cache_pkg::REFILL_WAIT;
               end else begin
                  state <= wtb_full_i ? cache_pkg::WTB_WAIT : cache_pkg::IDLE;
               end
            end
            cache_pkg::REFILL_WAIT: begin
               if (refill_ack_i) begin
                  state <= cache_pkg::IDLE;
               end
            end
            default: begin
               // stalled write, ack follows the push
               if (!wtb_full_i) begin
                  state <= cache_pkg::IDLE;
                  ack_q <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state == cache_pkg::IDLE) && data_req_i) begin
         req_q <= data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || invalidate_i) begin
         valid <= '0;
      end else if (refill_done) begin
         valid[idx] <= 1'b1;
      end
   end

   // refill a line, or merge bytes into a hit line
   always_ff @(posedge clk_i) begin
      if (refill_done) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= refill_rdata_i;
      end else if (write_hit_o) begin
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (req_q.wstrb[b]) begin
               data_mem[idx][8*b +: 8] <= req_q.wdata[8*b +: 8];
            end
         end
      end
   end

   assign read_hit_o   = lookup && !is_write && hit;
   assign read_miss_o  = lookup && !is_write && !hit;
   assign write_hit_o  = lookup && is_write && hit;
   assign write_miss_o = lookup && is_write && !hit;

   assign data_ack_o   = read_hit_o || refill_done || ack_q ||
                         (lookup && is_write && !wtb_full_i);
   assign data_rdata_o = refill_done ? refill_rdata_i : data_mem[idx];

   // every write goes through, no allocate on a miss
   assign wtb_push_o = ((lookup && is_write) || (state == cache_pkg::WTB_WAIT)) && !wtb_full_i;
   assign wtb_data_o = {req_q.addr, req_q.wdata, req_q.wstrb};

   // read waits for older writes to drain
   assign refill_req_o  = (state == cache_pkg::REFILL_WAIT) && wtb_empty_i;
   assign refill_addr_o = req_q.addr;

endmodule

`default_nettype wire

// ==== logic/cache_back_end.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_back_end (
   input  wire                          clk_i,
   input  wire                          reset_i,
   // write-through buffer
   input  wire                          wtb_empty_i,
   input  wire cache_pkg::wtb_entry_t   wtb_data_i,
   output logic                         wtb_pop_o,
   // line refill
   input  wire                          refill_req_i,
   input  wire  [cache_pkg::ADDR_W-1:0] refill_addr_i,
   output logic                         refill_ack_o,
   output logic [cache_pkg::DATA_W-1:0] refill_rdata_o,
   // memory port
   output logic                         be_req_o,
   output cache_pkg::be_req_t           be_o,
   input  wire                          be_ack_i,
   input  wire  [cache_pkg::DATA_W-1:0] be_rdata_i
);

   cache_pkg::be_state_e state;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state    <= cache_pkg::BE_IDLE;
         be_req_o <= 1'b0;
      end else begin
         case (state)
            cache_pkg::BE_IDLE: begin
               // writes first so a read never passes one
               if (!wtb_empty_i) begin
                  state    <= cache_pkg::BE_WRITE;
                  be_req_o <= 1'b1;
               end else if (refill_req_i) begin
                  state    <= cache_pkg::BE_READ;
                  be_req_o <= 1'b1;
               end
            end
            default: begin
               if (be_ack_i) begin
                  state    <= cache_pkg::BE_IDLE;
                  be_req_o <= 1'b0;
               end
            end
         endcase
      end
   end

   // fields held stable while the request is out
   always_ff @(posedge clk_i) begin
      if (state == cache_pkg::BE_IDLE) begin
         if (!wtb_empty_i) begin
            be_o.addr  <= wtb_data_i.addr;
            be_o.wdata <= wtb_data_i.wdata;
            be_o.wstrb <= wtb_data_i.wstrb;
         end else begin
            be_o.addr  <= refill_addr_i;
            be_o.wdata <= '0;
            be_o.wstrb <= '0;
         end
      end
   end

   // entry leaves the buffer only once memory has it
   assign wtb_pop_o      = (state == cache_pkg::BE_WRITE) && be_ack_i;
   assign refill_ack_o   = (state == cache_pkg::BE_READ) && be_ack_i;
   assign refill_rdata_o = be_rdata_i;

endmodule

`default_nettype wire

// ==== logic/cache_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_control (
   input  wire                               clk_i,
   input  wire                               reset_i,
   input  wire                               ctrl_req_i,
   input  wire  [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr_i,
   input  wire                               ctrl_write_i,
   input  wire                               read_hit_i,
   input  wire                               read_miss_i,
   input  wire                               write_hit_i,
   input  wire                               write_miss_i,
   input  wire                               wtb_empty_i,
   output logic                              ctrl_ack_o,
   output logic [cache_pkg::DATA_W-1:0]      ctrl_rdata_o,
   output logic                              invalidate_o
);

   // counters kept in control address order
   logic [cache_pkg::CNT_W-1:0] cnt [4];
   logic [3:0]                  events;
   cache_pkg::ctrl_reg_e        reg_sel;

   assign events  = {write_miss_i, write_hit_i, read_miss_i, read_hit_i};
   assign reg_sel = cache_pkg::ctrl_reg_e'(ctrl_addr_i);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < 4; i++) begin
            cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            // saturate at all ones
            if (events[i] && (cnt[i] != '1)) begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_ack_o   <= 1'b0;
         invalidate_o <= 1'b0;
      end else begin
         ctrl_ack_o   <= ctrl_req_i;
         invalidate_o <= ctrl_req_i && ctrl_write_i && (reg_sel == cache_pkg::CTRL_INVALIDATE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_req_i) begin
         case (reg_sel)
            cache_pkg::CTRL_READ_HIT, cache_pkg::CTRL_READ_MISS,
            cache_pkg::CTRL_WRITE_HIT, cache_pkg::CTRL_WRITE_MISS:
               ctrl_rdata_o <= {{(cache_pkg::DATA_W-cache_pkg::CNT_W){1'b0}},
                                cnt[ctrl_addr_i[1:0]]};
            cache_pkg::CTRL_WTB_EMPTY:
               ctrl_rdata_o <= {{(cache_pkg::DATA_W-1){1'b0}}, wtb_empty_i};
            default:
               ctrl_rdata_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top (
   input  wire                          clk_i,
   input  wire                          reset_i,
   // host port
   input  wire                          req_i,
   input  wire  [cache_pkg::ADDR_W:0]   addr_i,
   input  wire  [cache_pkg::DATA_W-1:0] wdata_i,
   input  wire  [cache_pkg::NBYTES-1:0] wstrb_i,
   output logic [cache_pkg::DATA_W-1:0] rdata_o,
   output logic                         ack_o,
   // memory port
   output logic                         be_req_o,
   output cache_pkg::be_req_t           be_o,
   input  wire                          be_ack_i,
   input  wire  [cache_pkg::DATA_W-1:0] be_rdata_i
);

   // front end to cache memory and control
   logic                               data_req;
   logic                               data_ack;
   cache_pkg::fe_req_t                 data;
   logic [cache_pkg::DATA_W-1:0]       data_rdata;
   logic                               ctrl_req;
   logic                               ctrl_ack;
   logic                               ctrl_write;
   logic [cache_pkg::CTRL_ADDR_W-1:0]  ctrl_addr;
   logic [cache_pkg::DATA_W-1:0]       ctrl_rdata;
   logic                               invalidate;
   // write-through buffer and refill
   logic                               wtb_push;
   logic                               wtb_pop;
   logic                               wtb_full;
   logic                               wtb_empty;
   cache_pkg::wtb_entry_t              wtb_in;
   cache_pkg::wtb_entry_t              wtb_out;
   logic                               refill_req;
   logic                               refill_ack;
   logic [cache_pkg::ADDR_W-1:0]       refill_addr;
   logic [cache_pkg::DATA_W-1:0]       refill_rdata;
   // counter events
   logic                               read_hit;
   logic                               read_miss;
   logic                               write_hit;
   logic                               write_miss;

   cache_front_end front_end (
      .clk_i, .reset_i,
      .req_i, .addr_i, .wdata_i, .wstrb_i, .rdata_o, .ack_o,
      .data_req_o   (data_req),
      .data_o       (data),
      .data_ack_i   (data_ack),
      .data_rdata_i (data_rdata),
      .ctrl_req_o   (ctrl_req),
      .ctrl_addr_o  (ctrl_addr),
      .ctrl_write_o (ctrl_write),
      .ctrl_ack_i   (ctrl_ack),
      .ctrl_rdata_i (ctrl_rdata)
   );

   cache_memory memory (
      .clk_i, .reset_i,
      .data_req_i     (data_req),
      .data_i         (data),
      .data_ack_o     (data_ack),
      .data_rdata_o   (data_rdata),
      .invalidate_i   (invalidate),
      .wtb_full_i     (wtb_full),
      .wtb_empty_i    (wtb_empty),
      .wtb_push_o     (wtb_push),
      .wtb_data_o     (wtb_in),
      .refill_req_o   (refill_req),
      .refill_addr_o  (refill_addr),
      .refill_ack_i   (refill_ack),
      .refill_rdata_i (refill_rdata),
      .read_hit_o     (read_hit),
      .read_miss_o    (read_miss),
      .write_hit_o    (write_hit),
      .write_miss_o   (write_miss)
   );

   write_through_buffer wtb (
      .clk_i, .reset_i,
      .push_i      (wtb_push),
      .push_data_i (wtb_in),
      .pop_i       (wtb_pop),
      .pop_data_o  (wtb_out),
      .full_o      (wtb_full),
      .empty_o     (wtb_empty)
   );

   cache_back_end back_end (
      .clk_i, .reset_i,
      .wtb_empty_i    (wtb_empty),
      .wtb_data_i     (wtb_out),
      .wtb_pop_o      (wtb_pop),
      .refill_req_i   (refill_req),
      .refill_addr_i  (refill_addr),
      .refill_ack_o   (refill_ack),
      .refill_rdata_o (refill_rdata),
      .be_req_o, .be_o, .be_ack_i, .be_rdata_i
   );

   cache_control control (
      .clk_i, .reset_i,
      .ctrl_req_i   (ctrl_req),
      .ctrl_addr_i  (ctrl_addr),
      .ctrl_write_i (ctrl_write),
      .read_hit_i   (read_hit),
      .read_miss_i  (read_miss),
      .write_hit_i  (write_hit),
      .write_miss_i (write_miss),
      .wtb_empty_i  (wtb_empty),
      .ctrl_ack_o   (ctrl_ack),
      .ctrl_rdata_o (ctrl_rdata),
      .invalidate_o (invalidate)
   );

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

   logic                          clk_i      = 1'b0;
   logic                          reset_i    = 1'b1;
   logic                          req_i;
   logic [cache_pkg::ADDR_W:0]    addr_i;
   logic [cache_pkg::DATA_W-1:0]  wdata_i;
   logic [cache_pkg::NBYTES-1:0]  wstrb_i;
   logic [cache_pkg::DATA_W-1:0]  rdata_o;
   logic                          ack_o;
   logic                          be_req_o;
   cache_pkg::be_req_t            be_o;
   logic                          be_ack_i   = 1'b0;
   logic [cache_pkg::DATA_W-1:0]  be_rdata_i = '0;

   // reference state: memory image, line tags, expected event counts
   logic [31:0] model_mem [1024];
   logic [31:0] resp_mem  [1024];
   logic [15:0] mvalid;
   logic [5:0]  mtag [16];
   int          exp_cnt [4];
   int          check_errors = 0;
   int          other_errors = 0;
   int          seed         = 77;
   int          resp_seed    = 77;
   int          wait_cnt     = -1;
   logic        slow_mem     = 1'b0;

   cache_top uut (
      .clk_i, .reset_i,
      .req_i, .addr_i, .wdata_i, .wstrb_i, .rdata_o, .ack_o,
      .be_req_o, .be_o, .be_ack_i, .be_rdata_i
   );

   always #2 clk_i = ~clk_i;

   function automatic logic [31:0] fill_word(input logic [9:0] a);
      return {a ^ 10'h2a5, 6'h15, ~a, a[5:0]};
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         check_errors++;
      end
   endtask

   // memory responder, 0 to 5 cycles per request
   always @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < 1024; i++) begin
            resp_mem[i] = fill_word(10'(i));
         end
         be_ack_i <= 1'b0;
         wait_cnt = -1;
      end else if (be_ack_i) begin
         // back end drops its request on this edge
         be_ack_i <= 1'b0;
      end else if (be_req_o) begin
         if (wait_cnt < 0) begin
            wait_cnt = slow_mem ? 5 : int'($unsigned($random(resp_seed)) % 6);
         end
         if (wait_cnt == 0) begin
            for (int b = 0; b < 4; b++) begin
               if (be_o.wstrb[b]) begin
                  resp_mem[be_o.addr][8*b +: 8] = be_o.wdata[8*b +: 8];
               end
            end
            be_rdata_i <= resp_mem[be_o.addr];
            be_ack_i   <= 1'b1;
            wait_cnt = -1;
         end else begin
            wait_cnt = wait_cnt - 1;
         end
      end
   end

   // one host request, cycles counted from the edge that samples req_i
   task automatic host_access(input logic [10:0] full_addr, input logic [31:0] wd,
                              input logic [3:0] ws, output logic [31:0] rd,
                              output int cycles);
      logic acked;
      acked = 1'b0;
      rd    = '0;
      @(posedge clk_i);
      req_i   <= 1'b1;
      addr_i  <= full_addr;
      wdata_i <= wd;
      wstrb_i <= ws;
      @(posedge clk_i);
      req_i <= 1'b0;
      cycles = 0;
      while (!acked && cycles < 200) begin
         @(posedge clk_i);
         cycles++;
         acked = ack_o;
      end
      if (acked) begin
         rd = rdata_o;
      end else begin
         $display("ERROR: no ack_o within 200 cycles for address %h", full_addr);
         other_errors++;
      end
   endtask

   task automatic do_read(input logic [9:0] a);
      logic [31:0] rd;
      int          cycles;
      logic        hit;
      hit = mvalid[a[3:0]] && (mtag[a[3:0]] == a[9:4]);
      if (hit) begin
         exp_cnt[0]++;
      end else begin
         // read miss allocates the line
         exp_cnt[1]++;
         mvalid[a[3:0]] = 1'b1;
         mtag[a[3:0]]   = a[9:4];
      end
      host_access({1'b0, a}, 32'h0, 4'h0, rd, cycles);
      check_value($sformatf("read data at %h", a), model_mem[a], rd);
      if (hit) begin
         check_value("read hit latency", 3, cycles);
      end
   endtask

   task automatic do_write(input logic [9:0] a, input logic [31:0] wd,
                           input logic [3:0] ws);
      logic [31:0] rd;
      int          cycles;
      if (mvalid[a[3:0]] && (mtag[a[3:0]] == a[9:4])) begin
         exp_cnt[2]++;
      end else begin
         exp_cnt[3]++;
      end
      for (int b = 0; b < 4; b++) begin
         if (ws[b]) begin
            model_mem[a][8*b +: 8] = wd[8*b +: 8];
         end
      end
      host_access({1'b0, a}, wd, ws, rd, cycles);
   endtask

   task automatic ctrl_read(input logic [2:0] reg_addr, output logic [31:0] rd);
      int cycles;
      host_access({1'b1, 7'h0, reg_addr}, 32'h0, 4'h0, rd, cycles);
      check_value("control read latency", 3, cycles);
   endtask

   task automatic ctrl_write(input logic [2:0] reg_addr);
      logic [31:0] rd;
      int          cycles;
      host_access({1'b1, 7'h0, reg_addr}, 32'h0, 4'hf, rd, cycles);
      check_value("control write latency", 3, cycles);
   endtask

   task automatic check_counters();
      logic [31:0] d;
      for (int i = 0; i < 4; i++) begin
         ctrl_read(3'(i), d);
         check_value($sformatf("counter %0d", i), exp_cnt[i], d);
      end
   endtask

   // wait for an empty buffer, then memory must equal the image
   task automatic drain_and_compare(input string phase);
      logic [31:0] st;
      int          tries;
      st    = '0;
      tries = 0;
      while (st[0] !== 1'b1 && tries < 100) begin
         ctrl_read(cache_pkg::CTRL_WTB_EMPTY, st);
         tries++;
      end
      if (st[0] !== 1'b1) begin
         $display("ERROR: write-through buffer still not empty after %0d polls", tries);
         other_errors++;
      end
      for (int i = 0; i < 1024; i++) begin
         check_value($sformatf("%s word %0d", phase, i), model_mem[i], resp_mem[i]);
      end
   endtask

   task automatic random_traffic(input int n_ops, input int span);
      logic [9:0]  a;
      logic [31:0] wd;
      logic [3:0]  ws;
      for (int n = 0; n < n_ops; n++) begin
         a = 10'($unsigned($random(seed)) % span);
         if (($unsigned($random(seed)) % 10) < 6) begin
            do_read(a);
            // immediate re-read must hit
            if (($unsigned($random(seed)) % 4) == 0) begin
               do_read(a);
            end
         end else begin
            wd = $random(seed);
            ws = 4'($random(seed));
            if (ws == 4'h0) begin
               ws = 4'hf;
            end
            do_write(a, wd, ws);
         end
      end
   endtask

   initial begin
      req_i   = 1'b0;
      addr_i  = '0;
      wdata_i = '0;
      wstrb_i = '0;
      mvalid  = '0;
      for (int i = 0; i < 1024; i++) begin
         model_mem[i] = fill_word(10'(i));
      end
      for (int i = 0; i < 4; i++) begin
         exp_cnt[i] = 0;
      end
      repeat (3) @(posedge clk_i);
      reset_i <= 1'b0;

      random_traffic(300, 64);
      drain_and_compare("after traffic");
      check_counters();

      // invalidate turns a cached line into a miss
      do_read(10'd5);
      do_read(10'd5);
      ctrl_write(cache_pkg::CTRL_INVALIDATE);
      mvalid = '0;
      do_read(10'd5);
      check_counters();

      // slow memory fills the buffer, writes arrive faster than they drain
      slow_mem <= 1'b1;
      for (int n = 0; n < 24; n++) begin
         do_write(10'($unsigned($random(seed)) % 1024), $random(seed), 4'hf);
      end
      drain_and_compare("after burst");
      slow_mem <= 1'b0;

      random_traffic(100, 1024);
      drain_and_compare("final");
      check_counters();

      $display("closing: %0d value mismatches, %0d other failures",
               check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
logic/cache_pkg.sv
logic/cache_front_end.sv
logic/write_through_buffer.sv
logic/cache_memory.sv
logic/cache_back_end.sv
logic/cache_control.sv
logic/cache_top.sv
verification/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module cache_tb -o cache_sim
out=$(./obj_dir/cache_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
   exit 0
fi
exit 1
